//--- source/pipe_pkg.sv
// ************************************************************
// datapath widths shared by the register-read stage
// ************************************************************

package pipe_pkg;

    // data and pc width
    localparam int xlen = 32;

    // register index width and register count
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;

    // exception code carried by each issue lane
    localparam int exp_w = 7;

    // free-running stable counter
    localparam int cnt_w = 64;

endpackage

//--- source/uop_pkg.sv
// ************************************************************
// micro-op word layout and decode codes
// ************************************************************

package uop_pkg;

    localparam int uop_w = 16;

    // field widths and positions inside the micro-op word
    localparam int itype_w = 3;
    localparam int src_w = 2;
    localparam int uop_type_lsb = 13; // bits 15:13
    localparam int uop_src1_lsb = 11; // bits 12:11
    localparam int uop_src2_lsb = 9;  // bits 10:9 with the opcode below

    // instruction types
    localparam logic [itype_w-1:0] itype_alu = 3'd0;
    localparam logic [itype_w-1:0] itype_mem = 3'd1;
    localparam logic [itype_w-1:0] itype_br  = 3'd2;

    // src1 select codes
    localparam logic [src_w-1:0] src1_rf    = 2'd0;
    localparam logic [src_w-1:0] src1_pc    = 2'd1;
    localparam logic [src_w-1:0] src1_zero  = 2'd2;
    localparam logic [src_w-1:0] src1_cntid = 2'd3;

    // src2 select codes
    localparam logic [src_w-1:0] src2_rf   = 2'd0;
    localparam logic [src_w-1:0] src2_imm  = 2'd1;
    localparam logic [src_w-1:0] src2_cntl = 2'd2;
    localparam logic [src_w-1:0] src2_cnth = 2'd3;

    function automatic logic [itype_w-1:0] uop_type(input logic [uop_w-1:0] u);
        return u[uop_type_lsb +: itype_w];
    endfunction

    function automatic logic [src_w-1:0] uop_src1(input logic [uop_w-1:0] u);
        return u[uop_src1_lsb +: src_w];
    endfunction

    function automatic logic [src_w-1:0] uop_src2(input logic [uop_w-1:0] u);
        return u[uop_src2_lsb +: src_w];
    endfunction

endpackage

//--- source/issue_if.sv
`timescale 1ns/1ps

// one issue lane as presented to the register-read stage
interface issue_if import pipe_pkg::*, uop_pkg::*; ();

    logic                  en;
    logic [uop_w-1:0]      uop;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc_next;
    logic [exp_w-1:0]      exp;
    logic [xlen-1:0]       imm;

    // issue side
    modport src (
        output en, uop, rd, rj, rk, pc, pc_next, exp, imm
    );

    // register-read lane side
    modport sink (
        input en, uop, rd, rj, rk, pc, pc_next, exp, imm
    );

endinterface

//--- source/wb_if.sv
`timescale 1ns/1ps

// both write-back ports coming back from the second execute stage
interface wb_if import pipe_pkg::*; ();

    logic                  en0;
    logic [reg_addr_w-1:0] addr0;
    logic [xlen-1:0]       data0;
    logic                  en1;
    logic [reg_addr_w-1:0] addr1;
    logic [xlen-1:0]       data1;

    modport src (
        output en0, addr0, data0, en1, addr1, data1
    );

    modport dst (
        input en0, addr0, data0, en1, addr1, data1
    );

endinterface

//--- source/regfile_array.sv
`timescale 1ns/1ps

module regfile_array import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    wb_if.dst                     wb,
    input  logic [reg_addr_w-1:0] rd_addr_a0,
    input  logic [reg_addr_w-1:0] rd_addr_a1,
    input  logic [reg_addr_w-1:0] rd_addr_b0,
    input  logic [reg_addr_w-1:0] rd_addr_b1,
    output logic [xlen-1:0]       rd_data_a0,
    output logic [xlen-1:0]       rd_data_a1,
    output logic [xlen-1:0]       rd_data_b0,
    output logic [xlen-1:0]       rd_data_b1
);

    // r0 has no storage
    logic [xlen-1:0] regs    [1:num_regs-1];
    logic [xlen-1:0] rf_next [0:num_regs-1];

    // ************************************************************
    // file contents after this cycle's writes
    // also serves as the forwarding path for reads
    // ************************************************************

    always_comb begin
        rf_next[0] = '0; // hardwired zero
        for (int i = 1; i < num_regs; i++) begin
            if (wb.en1 && wb.addr1 == reg_addr_w'(i)) begin
                rf_next[i] = wb.data1; // port 1 wins on a collision
            end else if (wb.en0 && wb.addr0 == reg_addr_w'(i)) begin
                rf_next[i] = wb.data0;
            end else begin
                rf_next[i] = regs[i];
            end
        end
    end

    // ************************************************************
    // storage
    // ************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= rf_next[i];
            end
        end
    end

    // read ports a serve lane 0 and b serve lane 1
    assign rd_data_a0 = rf_next[rd_addr_a0];
    assign rd_data_a1 = rf_next[rd_addr_a1];
    assign rd_data_b0 = rf_next[rd_addr_b0];
    assign rd_data_b1 = rf_next[rd_addr_b1];

endmodule

//--- source/stable_counter.sv
`timescale 1ns/1ps

// time base read by the rdtime-style operand sources
module stable_counter import pipe_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    output logic [cnt_w-1:0] count
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1; // wraps after 2^64 cycles
        end
    end

endmodule

//--- source/rf_lane.sv
`timescale 1ns/1ps

module rf_lane import pipe_pkg::*, uop_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    issue_if.sink                 iss,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data,
    input  logic [cnt_w-1:0]      count,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic                  en_out,
    output logic [uop_w-1:0]      uop_out,
    output logic [reg_addr_w-1:0] rd_out,
    output logic [reg_addr_w-1:0] rj_out,
    output logic [reg_addr_w-1:0] rk_out,
    output logic [xlen-1:0]       pc_out,
    output logic [xlen-1:0]       pc_next_out,
    output logic [exp_w-1:0]      exp_out,
    output logic [xlen-1:0]       imm_out,
    output logic [xlen-1:0]       src1_val,
    output logic [xlen-1:0]       src2_val
);

    logic [xlen-1:0] src1_nxt;
    logic [xlen-1:0] src2_nxt;

    assign rs1_addr = iss.rj;
    assign rs2_addr = iss.rk;

    // ************************************************************
    // operand select
    // ************************************************************

    always_comb begin
        src1_nxt = rs1_data; // non-alu types always read both registers
        src2_nxt = rs2_data;
        if (uop_type(iss.uop) == itype_alu) begin
            case (uop_src1(iss.uop))
                src1_pc:    src1_nxt = iss.pc;
                src1_zero:  src1_nxt = '0;
                src1_cntid: src1_nxt = '0; // no counter id source yet
                default:    src1_nxt = rs1_data;
            endcase
            case (uop_src2(iss.uop))
                src2_imm:  src2_nxt = iss.imm;
                src2_cntl: src2_nxt = count[xlen-1:0];
                src2_cnth: src2_nxt = count[cnt_w-1:xlen];
                default:   src2_nxt = rs2_data;
            endcase
        end
    end

    // ************************************************************
    // pipeline register toward execute
    // ************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_out   <= 1'b0;
            src1_val <= '0;
            src2_val <= '0;
        end else begin
            en_out <= iss.en; // valid follows the input every cycle
            if (iss.en) begin
                src1_val <= src1_nxt;
                src2_val <= src2_nxt;
            end
        end
    end

    // payload fields hold while the lane is idle
    always_ff @(posedge clk) begin
        if (iss.en) begin
            uop_out     <= iss.uop;
            rd_out      <= iss.rd;
            rj_out      <= iss.rj;
            rk_out      <= iss.rk;
            pc_out      <= iss.pc;
            pc_next_out <= iss.pc_next;
            exp_out     <= iss.exp;
            imm_out     <= iss.imm;
        end
    end

endmodule

//--- source/rf_stage.sv
`timescale 1ns/1ps

module rf_stage import pipe_pkg::*, uop_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // write-back from the second execute stage
    input  logic                  wb_en_0,
    input  logic [reg_addr_w-1:0] wb_addr_0,
    input  logic [xlen-1:0]       wb_data_0,
    input  logic                  wb_en_1,
    input  logic [reg_addr_w-1:0] wb_addr_1,
    input  logic [xlen-1:0]       wb_data_1,
    // lane 0 from issue
    input  logic                  eu0_en,
    input  logic [uop_w-1:0]      eu0_uop,
    input  logic [reg_addr_w-1:0] eu0_rd,
    input  logic [reg_addr_w-1:0] eu0_rj,
    input  logic [reg_addr_w-1:0] eu0_rk,
    input  logic [xlen-1:0]       eu0_pc,
    input  logic [xlen-1:0]       eu0_pc_next,
    input  logic [exp_w-1:0]      eu0_exp,
    input  logic [xlen-1:0]       eu0_imm,
    // lane 1 from issue
    input  logic                  eu1_en,
    input  logic [uop_w-1:0]      eu1_uop,
    input  logic [reg_addr_w-1:0] eu1_rd,
    input  logic [reg_addr_w-1:0] eu1_rj,
    input  logic [reg_addr_w-1:0] eu1_rk,
    input  logic [xlen-1:0]       eu1_pc,
    input  logic [xlen-1:0]       eu1_pc_next,
    input  logic [exp_w-1:0]      eu1_exp,
    input  logic [xlen-1:0]       eu1_imm,
    // lane 0 toward execute
    output logic                  eu0_en_out,
    output logic [uop_w-1:0]      eu0_uop_out,
    output logic [reg_addr_w-1:0] eu0_rd_out,
    output logic [reg_addr_w-1:0] eu0_rj_out,
    output logic [reg_addr_w-1:0] eu0_rk_out,
    output logic [xlen-1:0]       eu0_pc_out,
    output logic [xlen-1:0]       eu0_pc_next_out,
    output logic [exp_w-1:0]      eu0_exp_out,
    output logic [xlen-1:0]       eu0_imm_out,
    output logic [xlen-1:0]       eu0_src1,
    output logic [xlen-1:0]       eu0_src2,
    // lane 1 toward execute
    output logic                  eu1_en_out,
    output logic [uop_w-1:0]      eu1_uop_out,
    output logic [reg_addr_w-1:0] eu1_rd_out,
    output logic [reg_addr_w-1:0] eu1_rj_out,
    output logic [reg_addr_w-1:0] eu1_rk_out,
    output logic [xlen-1:0]       eu1_pc_out,
    output logic [xlen-1:0]       eu1_pc_next_out,
    output logic [exp_w-1:0]      eu1_exp_out,
    output logic [xlen-1:0]       eu1_imm_out,
    output logic [xlen-1:0]       eu1_src1,
    output logic [xlen-1:0]       eu1_src2
);

    logic [reg_addr_w-1:0] rd_addr_a0;
    logic [reg_addr_w-1:0] rd_addr_a1;
    logic [reg_addr_w-1:0] rd_addr_b0;
    logic [reg_addr_w-1:0] rd_addr_b1;
    logic [xlen-1:0]       rd_data_a0;
    logic [xlen-1:0]       rd_data_a1;
    logic [xlen-1:0]       rd_data_b0;
    logic [xlen-1:0]       rd_data_b1;
    logic [cnt_w-1:0]      count;

    wb_if    wb ();
    issue_if iss0 ();
    issue_if iss1 ();

    // ************************************************************
    // plain ports onto the bundles
    // ************************************************************

    assign wb.en0  = wb_en_0;
    assign wb.addr0 = wb_addr_0;
    assign wb.data0 = wb_data_0;
    assign wb.en1  = wb_en_1;
    assign wb.addr1 = wb_addr_1;
    assign wb.data1 = wb_data_1;

    assign iss0.en      = eu0_en;
    assign iss0.uop     = eu0_uop;
    assign iss0.rd      = eu0_rd;
    assign iss0.rj      = eu0_rj;
    assign iss0.rk      = eu0_rk;
    assign iss0.pc      = eu0_pc;
    assign iss0.pc_next = eu0_pc_next;
    assign iss0.exp     = eu0_exp;
    assign iss0.imm     = eu0_imm;

    assign iss1.en      = eu1_en;
    assign iss1.uop     = eu1_uop;
    assign iss1.rd      = eu1_rd;
    assign iss1.rj      = eu1_rj;
    assign iss1.rk      = eu1_rk;
    assign iss1.pc      = eu1_pc;
    assign iss1.pc_next = eu1_pc_next;
    assign iss1.exp     = eu1_exp;
    assign iss1.imm     = eu1_imm;

    // ************************************************************
    // blocks
    // ************************************************************

    regfile_array u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb         (wb),
        .rd_addr_a0 (rd_addr_a0),
        .rd_addr_a1 (rd_addr_a1),
        .rd_addr_b0 (rd_addr_b0),
        .rd_addr_b1 (rd_addr_b1),
        .rd_data_a0 (rd_data_a0),
        .rd_data_a1 (rd_data_a1),
        .rd_data_b0 (rd_data_b0),
        .rd_data_b1 (rd_data_b1)
    );

    stable_counter u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count)
    );

    rf_lane u_lane0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss         (iss0),
        .rs1_data    (rd_data_a0),
        .rs2_data    (rd_data_a1),
        .count       (count),
        .rs1_addr    (rd_addr_a0),
        .rs2_addr    (rd_addr_a1),
        .en_out      (eu0_en_out),
        .uop_out     (eu0_uop_out),
        .rd_out      (eu0_rd_out),
        .rj_out      (eu0_rj_out),
        .rk_out      (eu0_rk_out),
        .pc_out      (eu0_pc_out),
        .pc_next_out (eu0_pc_next_out),
        .exp_out     (eu0_exp_out),
        .imm_out     (eu0_imm_out),
        .src1_val    (eu0_src1),
        .src2_val    (eu0_src2)
    );

    rf_lane u_lane1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss         (iss1),
        .rs1_data    (rd_data_b0),
        .rs2_data    (rd_data_b1),
        .count       (count),
        .rs1_addr    (rd_addr_b0),
        .rs2_addr    (rd_addr_b1),
        .en_out      (eu1_en_out),
        .uop_out     (eu1_uop_out),
        .rd_out      (eu1_rd_out),
        .rj_out      (eu1_rj_out),
        .rk_out      (eu1_rk_out),
        .pc_out      (eu1_pc_out),
        .pc_next_out (eu1_pc_next_out),
        .exp_out     (eu1_exp_out),
        .imm_out     (eu1_imm_out),
        .src1_val    (eu1_src1),
        .src2_val    (eu1_src2)
    );

endmodule

//--- verification/tb_rf_stage.sv
`timescale 1ns/1ps

module tb_rf_stage import pipe_pkg::*, uop_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int trace_len    = 18;
    localparam int line_words   = 31; // wb 6, lane0 9, lane1 9, flag 1, expected 6
    localparam int lane_base    = 6;
    localparam int flag_idx     = 24;
    localparam int expect_base  = 25;

    logic                  clk;
    logic                  rst_n;
    logic                  wb_en_0, wb_en_1;
    logic [reg_addr_w-1:0] wb_addr_0, wb_addr_1;
    logic [xlen-1:0]       wb_data_0, wb_data_1;
    logic                  eu0_en, eu1_en;
    logic [uop_w-1:0]      eu0_uop, eu1_uop;
    logic [reg_addr_w-1:0] eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    logic [xlen-1:0]       eu0_pc, eu0_pc_next, eu0_imm, eu1_pc, eu1_pc_next, eu1_imm;
    logic [exp_w-1:0]      eu0_exp, eu1_exp;
    logic                  eu0_en_out, eu1_en_out;
    logic [uop_w-1:0]      eu0_uop_out, eu1_uop_out;
    logic [reg_addr_w-1:0] eu0_rd_out, eu0_rj_out, eu0_rk_out;
    logic [reg_addr_w-1:0] eu1_rd_out, eu1_rj_out, eu1_rk_out;
    logic [xlen-1:0]       eu0_pc_out, eu0_pc_next_out, eu0_imm_out, eu0_src1, eu0_src2;
    logic [xlen-1:0]       eu1_pc_out, eu1_pc_next_out, eu1_imm_out, eu1_src1, eu1_src2;
    logic [exp_w-1:0]      eu0_exp_out, eu1_exp_out;

    logic [31:0] trace_mem [0:trace_len*line_words-1];
    logic [31:0] hold [0:1][0:7]; // last enabled payload per lane
    logic        seen [0:1];

    rf_stage DUT (.*);

    always #(clk_period/2) clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic drive_line(input int k);
        int b;
        b = k * line_words;
        {wb_en_0, wb_addr_0, wb_data_0} = {trace_mem[b][0], trace_mem[b+1][4:0], trace_mem[b+2]};
        {wb_en_1, wb_addr_1, wb_data_1} = {trace_mem[b+3][0], trace_mem[b+4][4:0], trace_mem[b+5]};
        b = b + lane_base;
        eu0_en = trace_mem[b][0];
        eu0_uop = trace_mem[b+1][15:0];
        {eu0_rd, eu0_rj, eu0_rk} = {trace_mem[b+2][4:0], trace_mem[b+3][4:0], trace_mem[b+4][4:0]};
        {eu0_pc, eu0_pc_next} = {trace_mem[b+5], trace_mem[b+6]};
        {eu0_exp, eu0_imm} = {trace_mem[b+7][6:0], trace_mem[b+8]};
        b = b + 9;
        eu1_en = trace_mem[b][0];
        eu1_uop = trace_mem[b+1][15:0];
        {eu1_rd, eu1_rj, eu1_rk} = {trace_mem[b+2][4:0], trace_mem[b+3][4:0], trace_mem[b+4][4:0]};
        {eu1_pc, eu1_pc_next} = {trace_mem[b+5], trace_mem[b+6]};
        {eu1_exp, eu1_imm} = {trace_mem[b+7][6:0], trace_mem[b+8]};
    endtask

    // payload expected after the edge and held while a lane is idle
    task automatic track_payload(input int k);
        int b;
        for (int ln = 0; ln < 2; ln++) begin
            b = k * line_words + lane_base + 9 * ln;
            if (trace_mem[b][0]) begin
                seen[ln] = 1'b1;
                for (int f = 0; f < 8; f++) begin
                    hold[ln][f] = trace_mem[b+1+f];
                end
            end
        end
    endtask

    task automatic check_line(input int k);
        int b;
        b = k * line_words + expect_base;
        check_val("eu0_en_out", trace_mem[b], 32'(eu0_en_out));
        check_val("eu0_src1", trace_mem[b+1], eu0_src1);
        check_val("eu0_src2", trace_mem[b+2], eu0_src2);
        check_val("eu1_en_out", trace_mem[b+3], 32'(eu1_en_out));
        check_val("eu1_src1", trace_mem[b+4], eu1_src1);
        check_val("eu1_src2", trace_mem[b+5], eu1_src2);
        if (seen[0]) begin
            check_val("eu0_uop_out", 32'(hold[0][0][uop_w-1:0]), 32'(eu0_uop_out));
            check_val("eu0_rd_out", 32'(hold[0][1][reg_addr_w-1:0]), 32'(eu0_rd_out));
            check_val("eu0_rj_out", 32'(hold[0][2][reg_addr_w-1:0]), 32'(eu0_rj_out));
            check_val("eu0_rk_out", 32'(hold[0][3][reg_addr_w-1:0]), 32'(eu0_rk_out));
            check_val("eu0_pc_out", hold[0][4], eu0_pc_out);
            check_val("eu0_pc_next_out", hold[0][5], eu0_pc_next_out);
            check_val("eu0_exp_out", 32'(hold[0][6][exp_w-1:0]), 32'(eu0_exp_out));
            check_val("eu0_imm_out", hold[0][7], eu0_imm_out);
        end
        if (seen[1]) begin
            check_val("eu1_uop_out", 32'(hold[1][0][uop_w-1:0]), 32'(eu1_uop_out));
            check_val("eu1_rd_out", 32'(hold[1][1][reg_addr_w-1:0]), 32'(eu1_rd_out));
            check_val("eu1_rj_out", 32'(hold[1][2][reg_addr_w-1:0]), 32'(eu1_rj_out));
            check_val("eu1_rk_out", 32'(hold[1][3][reg_addr_w-1:0]), 32'(eu1_rk_out));
            check_val("eu1_pc_out", hold[1][4], eu1_pc_out);
            check_val("eu1_pc_next_out", hold[1][5], eu1_pc_next_out);
            check_val("eu1_exp_out", 32'(hold[1][6][exp_w-1:0]), 32'(eu1_exp_out));
            check_val("eu1_imm_out", hold[1][7], eu1_imm_out);
        end
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        {wb_en_0, wb_addr_0, wb_data_0, wb_en_1, wb_addr_1, wb_data_1} = '0;
        {eu0_en, eu0_uop, eu0_rd, eu0_rj, eu0_rk} = '0;
        {eu0_pc, eu0_pc_next, eu0_exp, eu0_imm} = '0;
        {eu1_en, eu1_uop, eu1_rd, eu1_rj, eu1_rk} = '0;
        {eu1_pc, eu1_pc_next, eu1_exp, eu1_imm} = '0;
        seen[0] = 1'b0;
        seen[1] = 1'b0;
        $readmemh("verification/rf_trace.txt", trace_mem);
        repeat (reset_cycles) @(posedge clk);
        for (int k = 0; k < trace_len; k++) begin
            @(negedge clk);
            rst_n = 1'b1; // line 0 is the first cycle out of reset
            drive_line(k);
            track_payload(k);
            @(posedge clk);
            #1;
            if (trace_mem[k*line_words+flag_idx][0]) begin
                check_line(k);
            end
        end
        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        #((reset_cycles + trace_len + 10) * clk_period);
        $display("timeout: the trace did not finish in time");
        $display("Errors found");
        $fatal(1);
    end

endmodule

//--- build.f
source/pipe_pkg.sv
source/uop_pkg.sv
source/issue_if.sv
source/wb_if.sv
source/regfile_array.sv
source/stable_counter.sv
source/rf_lane.sv
source/rf_stage.sv
verification/tb_rf_stage.sv

//--- verification/rf_trace.txt
// wb: en0 addr0 data0 en1 addr1 data1, then per lane: en uop rd rj rk pc pc_next exp imm
// then compare flag, then expected: en0_out src1_0 src2_0 en1_out src1_1 src2_1
// line k is sampled at the edge where the stable counter reads k
// reset values
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  1  0 0 0 0 0 0
// writes forwarded into same-cycle reads
1 1 11111111 1 2 22222222  1 0001 3 1 2 100 104 0 0  1 0001 4 0 1 200 204 1 0  1  1 11111111 22222222 1 0 11111111
// write to r0 is ignored
1 0 ffffffff 0 0 0  1 0001 5 2 1 108 10c 2 0  1 0001 6 0 0 208 20c 3 0  1  1 22222222 11111111 1 0 0
0 0 0 0 0 0  1 0001 7 0 2 110 114 4 0  1 0001 8 1 0 210 214 5 0  1  1 0 22222222 1 11111111 0
// both ports hit r5, port 1 wins
1 5 aaaaaaaa 1 5 bbbbbbbb  1 0001 9 5 5 118 11c 6 0  1 0001 a 5 1 218 21c 7 0  1  1 bbbbbbbb bbbbbbbb 1 bbbbbbbb 11111111
// disabled port does not forward
1 3 33333333 0 3 cccccccc  1 0001 b 5 3 120 124 8 0  1 0001 c 3 5 220 224 9 0  1  1 bbbbbbbb 33333333 1 33333333 bbbbbbbb
0 3 55555555 1 3 44444444  1 0001 d 3 0 128 12c a 0  1 0001 e 2 3 228 22c b 0  1  1 44444444 0 1 22222222 44444444
// alu selects: pc, imm, zero, counter low, counter id, counter high
0 0 0 0 0 0  1 0a02 1 1 2 130 134 c 12345678  1 0a02 2 3 3 230 234 7f fffffff0  1  1 130 12345678 1 230 fffffff0
0 0 0 0 0 0  1 1403 3 1 1 138 13c d 99  1 1e04 4 2 2 238 23c e 77  1  1 0 8 1 0 0
0 0 0 0 0 0  1 1e04 5 5 5 140 144 f 1  1 1403 6 5 5 240 244 10 2  1  1 0 0 1 0 9
// non-alu types read both registers
0 0 0 0 0 0  1 2a05 7 1 3 148 14c 11 dead  1 5e06 8 5 2 248 24c 12 beef  1  1 11111111 44444444 1 bbbbbbbb 22222222
// idle lanes hold their outputs
1 1 66666666 0 0 0  0 0a02 9 9 9 999 99c 33 abc  0 1403 a a a 888 88c 44 def  1  0 11111111 44444444 0 bbbbbbbb 22222222
0 0 0 0 0 0  1 0001 a 1 0 150 154 13 0  0 0001 1 1 1 777 77c 55 0  1  1 66666666 0 0 bbbbbbbb 22222222
0 0 0 0 0 0  0 0001 2 2 2 666 66c 66 0  1 0001 b 1 3 250 254 14 0  1  0 66666666 0 1 66666666 44444444
// counter read late, high half still zero
0 0 0 0 0 0  1 1403 c 0 0 158 15c 15 0  1 1e04 d 0 0 258 25c 16 0  1  1 0 e 1 0 0
1 1e 1e1e1e1e 1 1f 1f1f1f1f  0 0001 0 0 0 0 0 0 0  0 0001 0 0 0 0 0 0 0  1  0 0 e 0 0 0
0 0 0 0 0 0  1 0001 1f 1f 1e 160 164 7f 0  1 0a02 0 1f 1e 260 264 0 80000000  1  1 1f1f1f1f 1e1e1e1e 1 260 80000000
0 0 0 0 0 0  1 1403 1 0 0 168 16c 1 0  0 0001 0 0 0 0 0 0 0  1  1 0 11 0 260 80000000
